// File: Makefile
TOP = tb_adc_monitor

.PHONY: all lint clean

# Build, run, then look for the pass line in the simulator output
all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

obj_dir/V$(TOP): src.f $(wildcard *.sv) $(wildcard *.svh)
	verilator --binary --timing --assert -Wno-fatal -j 0 \
		-f src.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: adc_mon_defs.svh
`ifndef ADC_MON_DEFS_SVH
`define ADC_MON_DEFS_SVH

// ---------------------------------------------------------------------------
// I2C target identity
// ---------------------------------------------------------------------------
`define ADC_I2C_ADDR        7'h50
`define ADC_ID_BYTE         8'hAF

// ---------------------------------------------------------------------------
// Sample storage and stream format
// ---------------------------------------------------------------------------
`define ADC_NUM_CHANNELS    5
`define ADC_SAMPLE_BITS     12
`define ADC_STREAM_CH_BITS  5

// Sequencer slot numbers of the monitored inputs
`define ADC_CH0_ID          5'd1
`define ADC_CH1_ID          5'd2
`define ADC_CH2_ID          5'd3
`define ADC_CH3_ID          5'd4
`define ADC_CH4_ID          5'd6

// Control, ID, then lower/upper byte of each channel
`define ADC_NUM_BYTE_REGS   12

`endif

// File: adc_monitor_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_mon_defs.svh"

module adc_monitor_top (
    input  logic                            clk_core,
    input  logic                            reset_n,
    input  logic                            scl,
    input  logic                            sda_in,
    output logic                            sda_oe,
    input  logic                            adc_valid,
    input  logic [`ADC_STREAM_CH_BITS-1:0]  adc_channel,
    input  logic [`ADC_SAMPLE_BITS-1:0]     adc_data,
    input  logic                            adc_sop,
    input  logic                            adc_eop,
    output logic                            adc_run
);

    i2c_bus_if          bus ();
    adc_pkg::byte_idx_t rd_idx;
    logic [7:0]         rd_byte;

    // ------------------------------------------------------------------------
    // I2C side
    // ------------------------------------------------------------------------
    i2c_line_sampler u_line_sampler (
        .clk_core (clk_core),
        .reset_n  (reset_n),
        .scl      (scl),
        .sda_in   (sda_in),
        .bus      (bus.sampler)
    );

    i2c_target u_target (
        .clk_core (clk_core),
        .reset_n  (reset_n),
        .bus      (bus.target),
        .sda_oe   (sda_oe),
        .adc_run  (adc_run),
        .rd_idx   (rd_idx),
        .rd_byte  (rd_byte)
    );

    // ------------------------------------------------------------------------
    // Sequencer side
    // ------------------------------------------------------------------------
    adc_sample_store u_sample_store (
        .clk_core    (clk_core),
        .reset_n     (reset_n),
        .adc_valid   (adc_valid),
        .adc_channel (adc_channel),
        .adc_data    (adc_data),
        .adc_sop     (adc_sop),
        .adc_eop     (adc_eop),
        .adc_run     (adc_run),
        .rd_idx      (rd_idx),
        .rd_byte     (rd_byte)
    );

endmodule

`default_nettype wire

// File: adc_pkg.sv
`default_nettype none

`include "adc_mon_defs.svh"

package adc_pkg;

    // Channel number as carried on the sequencer response stream
    typedef logic [`ADC_STREAM_CH_BITS-1:0] stream_ch_t;

    // Capture view, zero pad above the converter result
    typedef struct packed {
        logic [15-`ADC_SAMPLE_BITS:0] pad;
        logic [`ADC_SAMPLE_BITS-1:0]  data;
    } sample_raw_t;

    // Bus view, two bytes served one at a time
    typedef struct packed {
        logic [7:0] upper;
        logic [7:0] lower;
    } sample_bytes_t;

    typedef union packed {
        sample_raw_t   raw;
        sample_bytes_t bytes;
    } sample_t;

    // Location in the readable byte map
    typedef logic [3:0] byte_idx_t;

endpackage

`default_nettype wire

// File: adc_sample_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_mon_defs.svh"

module adc_sample_store (
    input  logic                         clk_core,
    input  logic                         reset_n,
    input  logic                         adc_valid,
    input  adc_pkg::stream_ch_t          adc_channel,
    input  logic [`ADC_SAMPLE_BITS-1:0]  adc_data,
    input  logic                         adc_sop,
    input  logic                         adc_eop,
    input  logic                         adc_run,
    input  adc_pkg::byte_idx_t           rd_idx,
    output logic [7:0]                   rd_byte
);

    localparam adc_pkg::stream_ch_t ch_ids [`ADC_NUM_CHANNELS] = '{
        `ADC_CH0_ID, `ADC_CH1_ID, `ADC_CH2_ID, `ADC_CH3_ID, `ADC_CH4_ID
    };

    logic [`ADC_SAMPLE_BITS-1:0] raw      [`ADC_NUM_CHANNELS];
    logic [`ADC_SAMPLE_BITS-1:0] raw_next [`ADC_NUM_CHANNELS];
    adc_pkg::sample_t            pub      [`ADC_NUM_CHANNELS];

    // Beat on the eop cycle still lands in the published set
    always_comb begin
        for (int i = 0; i < `ADC_NUM_CHANNELS; i++) begin
            raw_next[i] = (adc_valid && adc_channel == ch_ids[i]) ? adc_data : raw[i];
        end
    end

    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            for (int i = 0; i < `ADC_NUM_CHANNELS; i++) begin
                raw[i] <= '0;
                pub[i] <= '0;
            end
        end else begin
            raw <= raw_next;
            if (adc_valid && adc_eop) begin
                for (int i = 0; i < `ADC_NUM_CHANNELS; i++) begin
                    pub[i].raw.pad  <= '0;
                    pub[i].raw.data <= raw_next[i];
                end
            end
        end
    end

    // Byte map: control, ID, then lower/upper per channel
    always_comb begin
        rd_byte = 8'h00;
        if (rd_idx == 4'd0) begin
            rd_byte = {7'b0000001, adc_run};
        end else if (rd_idx == 4'd1) begin
            rd_byte = `ADC_ID_BYTE;
        end
        for (int i = 0; i < `ADC_NUM_CHANNELS; i++) begin
            if (rd_idx == adc_pkg::byte_idx_t'(2 * i + 2)) begin
                rd_byte = pub[i].bytes.lower;
            end
            if (rd_idx == adc_pkg::byte_idx_t'(2 * i + 3)) begin
                rd_byte = pub[i].bytes.upper;
            end
        end
    end

    // Packet framing only on valid beats
    assert property (@(posedge clk_core) disable iff (!reset_n)
        (adc_eop || adc_sop) |-> adc_valid);

endmodule

`default_nettype wire

// File: i2c_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// Conditioned bus events, all in the clk_core domain
interface i2c_bus_if;

    logic start;
    logic stop;
    logic scl_rise;
    logic scl_fall;
    logic sda;

    modport sampler (
        output start,
        output stop,
        output scl_rise,
        output scl_fall,
        output sda
    );

    modport target (
        input start,
        input stop,
        input scl_rise,
        input scl_fall,
        input sda
    );

endinterface

`default_nettype wire

// File: i2c_line_sampler.sv
`timescale 1ns/1ps
`default_nettype none

module i2c_line_sampler (
    input  logic       clk_core,
    input  logic       reset_n,
    input  logic       scl,
    input  logic       sda_in,
    i2c_bus_if.sampler bus
);

    logic [1:0] scl_sync;
    logic [1:0] sda_sync;
    logic       scl_prev;
    logic       sda_prev;

    // Idle bus is high on both lines, so start from ones
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda_in};
            scl_prev <= scl_sync[1];
            sda_prev <= sda_sync[1];
        end
    end

    // Registered detect, third cycle after the pin moves
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            bus.start    <= 1'b0;
            bus.stop     <= 1'b0;
            bus.scl_rise <= 1'b0;
            bus.scl_fall <= 1'b0;
            bus.sda      <= 1'b1;
        end else begin
            // SDA edges only count as START/STOP with SCL steady high
            bus.start    <= scl_sync[1] && scl_prev && sda_prev && !sda_sync[1];
            bus.stop     <= scl_sync[1] && scl_prev && !sda_prev && sda_sync[1];
            bus.scl_rise <= scl_sync[1] && !scl_prev;
            bus.scl_fall <= !scl_sync[1] && scl_prev;
            bus.sda      <= sda_sync[1];
        end
    end

endmodule

`default_nettype wire

// File: i2c_pkg.sv
`default_nettype none

package i2c_pkg;

    // First data byte of a write, selects control or one channel
    typedef logic [2:0] reg_idx_t;

    // Where the target is inside the current transfer
    typedef enum logic [2:0] {
        ph_idle,
        ph_address,
        ph_pointer,
        ph_write_data,
        ph_read_data,
        ph_ignore
    } xfer_phase_t;

endpackage

`default_nettype wire

// File: i2c_target.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_mon_defs.svh"

module i2c_target (
    input  logic               clk_core,
    input  logic               reset_n,
    i2c_bus_if.target          bus,
    output logic               sda_oe,
    output logic               adc_run,
    output adc_pkg::byte_idx_t rd_idx,
    input  logic [7:0]         rd_byte
);

    i2c_pkg::xfer_phase_t phase;
    i2c_pkg::reg_idx_t    reg_idx;
    adc_pkg::byte_idx_t   ptr;
    adc_pkg::byte_idx_t   ptr_inc;
    logic [3:0]           bit_cnt;
    logic [7:0]           shift_in;
    logic [7:0]           tx_shift;
    logic [7:0]           load_byte;
    logic                 addr_match;
    logic                 scl_high;

    assign addr_match = (shift_in[7:1] == `ADC_I2C_ADDR);
    assign rd_idx     = ptr;

    // Past the map the pointer parks and reads give zero
    assign load_byte = (ptr < `ADC_NUM_BYTE_REGS) ? rd_byte : 8'h00;
    assign ptr_inc   = (ptr < `ADC_NUM_BYTE_REGS) ? ptr + 4'd1 : ptr;

    // SCL level as seen through the event pulses
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            scl_high <= 1'b1;
        end else if (bus.scl_rise) begin
            scl_high <= 1'b1;
        end else if (bus.scl_fall) begin
            scl_high <= 1'b0;
        end
    end

    // ------------------------------------------------------------------------
    // Transfer FSM with bit_cnt 8 as the ACK slot
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_core or negedge reset_n) begin
        if (!reset_n) begin
            phase    <= i2c_pkg::ph_idle;
            reg_idx  <= '0;
            ptr      <= '0;
            bit_cnt  <= '0;
            shift_in <= '0;
            tx_shift <= '0;
            sda_oe   <= 1'b0;
            adc_run  <= 1'b0;
        end else if (bus.start) begin
            phase   <= i2c_pkg::ph_address;
            // The SCL fall that closes the START wraps this to zero
            bit_cnt <= 4'hF;
            sda_oe  <= 1'b0;
        end else if (bus.stop) begin
            phase   <= i2c_pkg::ph_idle;
            bit_cnt <= '0;
            sda_oe  <= 1'b0;
        end else if (phase != i2c_pkg::ph_idle && phase != i2c_pkg::ph_ignore) begin
            if (bus.scl_rise) begin
                if (bit_cnt != 4'd8) begin
                    shift_in <= {shift_in[6:0], bus.sda};
                end else if (phase == i2c_pkg::ph_read_data && bus.sda) begin
                    // Master NACK ends the read
                    phase <= i2c_pkg::ph_ignore;
                end else if (phase == i2c_pkg::ph_write_data && reg_idx == '0) begin
                    adc_run <= shift_in[0];
                end
            end else if (bus.scl_fall) begin
                if (bit_cnt == 4'd7) begin
                    bit_cnt <= 4'd8;
                    if (phase == i2c_pkg::ph_address) begin
                        sda_oe <= addr_match;
                    end else begin
                        sda_oe <= (phase != i2c_pkg::ph_read_data);
                    end
                end else if (bit_cnt == 4'd8) begin
                    bit_cnt <= '0;
                    sda_oe  <= 1'b0;
                    case (phase)
                        i2c_pkg::ph_address: begin
                            if (!addr_match) begin
                                phase <= i2c_pkg::ph_ignore;
                            end else if (shift_in[0]) begin
                                phase    <= i2c_pkg::ph_read_data;
                                tx_shift <= load_byte;
                                sda_oe   <= !load_byte[7];
                                ptr      <= ptr_inc;
                            end else begin
                                phase <= i2c_pkg::ph_pointer;
                            end
                        end
                        i2c_pkg::ph_pointer: begin
                            reg_idx <= shift_in[2:0];
                            ptr     <= {shift_in[2:0], 1'b0};
                            phase   <= i2c_pkg::ph_write_data;
                        end
                        i2c_pkg::ph_read_data: begin
                            tx_shift <= load_byte;
                            sda_oe   <= !load_byte[7];
                            ptr      <= ptr_inc;
                        end
                        default: begin
                        end
                    endcase
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                    if (phase == i2c_pkg::ph_read_data) begin
                        tx_shift <= {tx_shift[6:0], 1'b0};
                        sda_oe   <= !tx_shift[6];
                    end
                end
            end
        end
    end

    // SDA only moves while SCL is low or on a STOP release
    assert property (@(posedge clk_core) disable iff (!reset_n)
        $changed(sda_oe) |-> !scl_high || $past(bus.stop));

    // Once the target drops out it stays off the bus
    assert property (@(posedge clk_core) disable iff (!reset_n)
        (phase == i2c_pkg::ph_ignore) && bus.scl_fall |=> !sda_oe);

endmodule

`default_nettype wire

// File: src.f
+incdir+.
adc_pkg.sv
i2c_pkg.sv
i2c_bus_if.sv
i2c_line_sampler.sv
i2c_target.sv
adc_sample_store.sv
adc_monitor_top.sv
tb_checker.sv
tb_adc_monitor.sv

// File: tb_adc_monitor.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_mon_defs.svh"

module tb_adc_monitor;

    localparam int clk_period   = 4;
    localparam int phase_cycles = 10;
    // Longest transaction is START, eleven bytes with ACK and STOP, plus margin
    localparam int txn_cycles   = 2400;
    localparam int max_txns     = 80;
    localparam int timeout_ns   = max_txns * txn_cycles * clk_period * 2;

    logic                           clk_core;
    logic                           reset_n;
    logic                           scl;
    logic                           sda_drv;
    logic                           sda_in;
    logic                           sda_oe;
    logic                           adc_valid;
    logic [`ADC_STREAM_CH_BITS-1:0] adc_channel;
    logic [`ADC_SAMPLE_BITS-1:0]    adc_data;
    logic                           adc_sop;
    logic                           adc_eop;
    logic                           adc_run;

    // Open-drain SDA is low when either side pulls
    assign sda_in = sda_drv && !sda_oe;

    initial begin
        clk_core = 1'b0;
        forever #(clk_period / 2) clk_core = ~clk_core;
    end

    adc_monitor_top u_adc_monitor_top (
        .clk_core    (clk_core),
        .reset_n     (reset_n),
        .scl         (scl),
        .sda_in      (sda_in),
        .sda_oe      (sda_oe),
        .adc_valid   (adc_valid),
        .adc_channel (adc_channel),
        .adc_data    (adc_data),
        .adc_sop     (adc_sop),
        .adc_eop     (adc_eop),
        .adc_run     (adc_run)
    );

    tb_checker u_checker (
        .clk_core    (clk_core),
        .reset_n     (reset_n),
        .adc_valid   (adc_valid),
        .adc_channel (adc_channel),
        .adc_data    (adc_data),
        .adc_eop     (adc_eop),
        .adc_run     (adc_run)
    );

    task automatic tick(input int n);
        repeat (n) @(posedge clk_core);
        #1;
    endtask

    // -------------------------------------------------------------------------
    // I2C master that moves SDA only in the middle of SCL low
    // -------------------------------------------------------------------------
    task automatic put_bit(input logic b);
        tick(phase_cycles / 2);
        sda_drv = b;
        tick(phase_cycles / 2);
        scl = 1'b1;
        tick(phase_cycles);
        scl = 1'b0;
    endtask

    task automatic get_bit(output logic b);
        tick(2);
        sda_drv = 1'b1;
        tick(phase_cycles - 2);
        scl = 1'b1;
        tick(phase_cycles - 1);
        b = sda_in;
        tick(1);
        scl = 1'b0;
    endtask

    task automatic bus_start();
        tick(phase_cycles);
        sda_drv = 1'b0;
        tick(phase_cycles);
        scl = 1'b0;
    endtask

    task automatic bus_stop();
        tick(phase_cycles / 2);
        sda_drv = 1'b0;
        tick(phase_cycles / 2);
        scl = 1'b1;
        tick(phase_cycles);
        sda_drv = 1'b1;
        tick(phase_cycles);
    endtask

    task automatic send_byte(input logic [7:0] b, output logic acked);
        logic ack_bit;
        for (int i = 7; i >= 0; i--) begin
            put_bit(b[i]);
        end
        get_bit(ack_bit);
        acked = !ack_bit;
    endtask

    task automatic recv_byte(input logic last, output logic [7:0] b);
        for (int i = 7; i >= 0; i--) begin
            get_bit(b[i]);
        end
        put_bit(last);
    endtask

    // Address, register index and an optional data byte
    task automatic write_reg(input logic [6:0] addr, input logic [2:0] idx,
                             input logic with_data, input logic [7:0] data);
        logic acked;
        logic own;
        own = (addr == `ADC_I2C_ADDR);
        bus_start();
        send_byte({addr, 1'b0}, acked);
        u_checker.check_ack(own, acked, "address");
        // Bytes to a foreign address still go out in full
        if (acked || !own) begin
            send_byte({5'b00000, idx}, acked);
            u_checker.check_ack(own, acked, "register index");
            if (with_data) begin
                send_byte(data, acked);
                u_checker.check_ack(own, acked, "data");
                if (own && idx == 3'd0) begin
                    u_checker.set_run(data[0]);
                end
            end
        end
        bus_stop();
    endtask

    task automatic read_regs(input logic [2:0] idx, input int count);
        logic       acked;
        logic [7:0] b;
        write_reg(`ADC_I2C_ADDR, idx, 1'b0, 8'h00);
        bus_start();
        send_byte({`ADC_I2C_ADDR, 1'b1}, acked);
        u_checker.check_ack(1'b1, acked, "read address");
        if (acked) begin
            for (int k = 0; k < count; k++) begin
                recv_byte(k == count - 1, b);
                u_checker.check_byte(2 * int'(idx) + k, b);
            end
        end
        bus_stop();
    endtask

    task automatic read_channels();
        for (int r = 1; r <= `ADC_NUM_CHANNELS; r++) begin
            read_regs(3'(r), 2);
        end
    endtask

    // Random channel IDs including unused ones, with eop on the last beat if asked
    task automatic send_stream(input int beats, input logic with_eop);
        for (int i = 0; i < beats; i++) begin
            adc_valid   = 1'b1;
            adc_channel = 5'($urandom_range(7, 0));
            adc_data    = 12'($urandom);
            adc_eop     = with_eop && (i == beats - 1);
            tick(1);
        end
        adc_valid = 1'b0;
        adc_eop   = 1'b0;
        tick(2);
    endtask

    initial begin
        #(timeout_ns);
        $display("Timeout: the run did not finish within %0d ns", timeout_ns);
        $display("Errors found");
        $finish;
    end

    // -------------------------------------------------------------------------
    // Test sequence
    // -------------------------------------------------------------------------
    initial begin
        logic [7:0] data;
        logic [6:0] addr;
        void'($urandom(32'hb5ca3413));
        reset_n     = 1'b0;
        scl         = 1'b1;
        sda_drv     = 1'b1;
        adc_valid   = 1'b0;
        adc_channel = '0;
        adc_data    = '0;
        adc_sop     = 1'b0;
        adc_eop     = 1'b0;
        repeat (10) @(posedge clk_core);
        #1;
        reset_n = 1'b1;
        tick(5);

        u_checker.begin_test("reset state");
        u_checker.check_run();
        read_regs(3'd0, 2);
        u_checker.end_test();

        // Random run bit first, then the other value
        u_checker.begin_test("run bit write");
        data = 8'($urandom);
        repeat (2) begin
            write_reg(`ADC_I2C_ADDR, 3'd0, 1'b1, data);
            u_checker.check_run();
            read_regs(3'd0, 2);
            data = {7'($urandom), !data[0]};
        end
        u_checker.end_test();

        u_checker.begin_test("stream capture");
        repeat (4) begin
            send_stream($urandom_range(20, 5), 1'b1);
            read_channels();
        end
        u_checker.end_test();

        // Nothing shows until an eop beat publishes
        u_checker.begin_test("publish on eop");
        send_stream(12, 1'b0);
        read_channels();
        send_stream(1, 1'b1);
        read_channels();
        u_checker.end_test();

        u_checker.begin_test("auto-increment");
        read_regs(3'd1, 10);
        read_regs(3'd6, 2);
        read_regs(3'd7, 2);
        u_checker.end_test();

        u_checker.begin_test("foreign address");
        do begin
            addr = 7'($urandom);
        end while (addr == `ADC_I2C_ADDR);
        write_reg(addr, 3'd0, 1'b1, {7'($urandom), !u_checker.run_model});
        u_checker.check_run();
        read_regs(3'd0, 2);
        read_regs(3'd1, 10);
        u_checker.end_test();

        u_checker.report_counts();
        if (u_checker.err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "adc_mon_defs.svh"

module tb_checker (
    input  logic                            clk_core,
    input  logic                            reset_n,
    input  logic                            adc_valid,
    input  logic [`ADC_STREAM_CH_BITS-1:0]  adc_channel,
    input  logic [`ADC_SAMPLE_BITS-1:0]     adc_data,
    input  logic                            adc_eop,
    input  logic                            adc_run
);

    logic [`ADC_SAMPLE_BITS-1:0] raw_model [`ADC_NUM_CHANNELS];
    logic [`ADC_SAMPLE_BITS-1:0] pub_model [`ADC_NUM_CHANNELS];
    logic                        run_model;
    int                          err_count;
    int                          test_count;
    int                          failed_tests;
    int                          test_err_base;
    string                       test_name;

    initial begin
        run_model     = 1'b0;
        err_count     = 0;
        test_count    = 0;
        failed_tests  = 0;
        test_err_base = 0;
    end

    // Stream channel number to storage slot, -1 for unmonitored IDs
    function automatic int slot_of(input logic [`ADC_STREAM_CH_BITS-1:0] ch);
        case (ch)
            `ADC_CH0_ID: return 0;
            `ADC_CH1_ID: return 1;
            `ADC_CH2_ID: return 2;
            `ADC_CH3_ID: return 3;
            `ADC_CH4_ID: return 4;
            default:     return -1;
        endcase
    endfunction

    // -------------------------------------------------------------------------
    // Reference model of the sample store
    // -------------------------------------------------------------------------
    always @(posedge clk_core or negedge reset_n) begin : model_update
        int slot;
        if (!reset_n) begin
            for (int i = 0; i < `ADC_NUM_CHANNELS; i++) begin
                raw_model[i] = '0;
                pub_model[i] = '0;
            end
        end else if (adc_valid) begin
            slot = slot_of(adc_channel);
            if (slot >= 0) begin
                raw_model[slot] = adc_data;
            end
            // Beat carrying eop is part of the published set
            if (adc_eop) begin
                pub_model = raw_model;
            end
        end
    end

    function automatic logic [7:0] expected_byte(input int loc);
        int ch;
        ch = (loc - 2) / 2;
        if (loc == 0) return {7'b0000001, run_model};
        if (loc == 1) return `ADC_ID_BYTE;
        if (loc >= `ADC_NUM_BYTE_REGS) return 8'h00;
        if (loc % 2 == 0) return pub_model[ch][7:0];
        return 8'(pub_model[ch] >> 8);
    endfunction

    task automatic begin_test(input string name);
        test_name     = name;
        test_err_base = err_count;
        test_count++;
    endtask

    task automatic end_test();
        int errs;
        errs = err_count - test_err_base;
        if (errs == 0) begin
            $display("Test %0d %s: passed", test_count, test_name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: failed with %0d errors", test_count, test_name, errs);
        end
    endtask

    task automatic check_byte(input int loc, input logic [7:0] got);
        logic [7:0] exp;
        exp = expected_byte(loc);
        if (got !== exp) begin
            err_count++;
            $display("Mismatch at %0t: byte location %0d read %02h, expected %02h",
                     $time, loc, got, exp);
        end
    endtask

    task automatic check_ack(input logic exp, input logic got, input string what);
        if (got !== exp) begin
            err_count++;
            if (exp) begin
                $display("Failure at %0t: the target did not acknowledge the %s byte",
                         $time, what);
            end else begin
                $display("Failure at %0t: the target acknowledged a foreign %s byte",
                         $time, what);
            end
        end
    endtask

    task automatic set_run(input logic b);
        run_model = b;
    endtask

    task automatic check_run();
        if (adc_run !== run_model) begin
            err_count++;
            $display("Mismatch at %0t: adc_run is %0b, expected %0b", $time, adc_run, run_model);
        end
    endtask

    task automatic report_counts();
        $display("Summary: %0d tests, %0d failed, %0d errors", test_count, failed_tests,
                 err_count);
    endtask

endmodule

`default_nettype wire
